// File: compile.f
hdl/harp_pkg.sv
hdl/class_if.sv
hdl/reg_access_if.sv
hdl/opcode_classifier.sv
hdl/reg_access_decoder.sv
hdl/decode_out_reg.sv
hdl/harp_decoder.sv
tests/decode_checker.sv
tests/tb_harp_decoder.sv

// File: hdl/class_if.sv
// opcode class bundle
// carries the class, ALU operation and function-unit flags
// from the opcode classifier to the register decoder and output stage

`timescale 1ns/1ps
`default_nettype none

interface class_if;
  import harp_pkg::*;

  op_class_e op_class;
  alu_op_e   alu_op;
  logic      pc_jump;
  logic      mem_read;
  logic      mem_write;

  modport src (
    output op_class, alu_op, pc_jump, mem_read, mem_write
  );

  modport dst (
    input op_class, alu_op, pc_jump, mem_read, mem_write
  );

endinterface

`default_nettype wire

// File: hdl/decode_out_reg.sv
// decode output register
// captures the decoded word on a valid instruction, loads an all-zero
// bubble otherwise; dec_valid trails instr_valid by one cycle

`timescale 1ns/1ps
`default_nettype none

module decode_out_reg (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            instr_valid,
  class_if.dst                                 cls,
  reg_access_if.dst                            acc,
  output logic                                 dec_valid,
  output harp_pkg::op_class_e                  op_class,
  output harp_pkg::alu_op_e                    alu_ctl,
  output logic                                 pc_jump,
  output logic                                 mem_read,
  output logic                                 mem_write,
  output logic                                 predicated,
  output harp_pkg::reg_addr_t                  pred_operand,
  output logic                                 gpr_read_en,
  output logic                                 pred_read_en,
  output logic                                 gpr_write_en,
  output logic                                 pred_write_en,
  output logic [harp_pkg::NUM_RD_PORTS-1:0]    gpr_rd_en,
  output harp_pkg::reg_addr_t                  gpr_rd_addr_0,
  output harp_pkg::reg_addr_t                  gpr_rd_addr_1,
  output harp_pkg::reg_addr_t                  gpr_rd_addr_2,
  output logic [harp_pkg::NUM_RD_PORTS-1:0]    pred_rd_en,
  output harp_pkg::reg_addr_t                  pred_rd_addr_0,
  output harp_pkg::reg_addr_t                  pred_rd_addr_1,
  output harp_pkg::reg_addr_t                  pred_rd_addr_2
);
  import harp_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  // reset and bubble both leave every control at zero
  always_ff @(posedge clk) begin
    if (rst || !instr_valid) begin
      op_class       <= CL_NONE;
      alu_ctl        <= ALU_NOP;
      pc_jump        <= 1'b0;
      mem_read       <= 1'b0;
      mem_write      <= 1'b0;
      predicated     <= 1'b0;
      pred_operand   <= '0;
      gpr_read_en    <= 1'b0;
      pred_read_en   <= 1'b0;
      gpr_write_en   <= 1'b0;
      pred_write_en  <= 1'b0;
      gpr_rd_en      <= '0;
      gpr_rd_addr_0  <= '0;
      gpr_rd_addr_1  <= '0;
      gpr_rd_addr_2  <= '0;
      pred_rd_en     <= '0;
      pred_rd_addr_0 <= '0;
      pred_rd_addr_1 <= '0;
      pred_rd_addr_2 <= '0;
    end else begin
      op_class       <= cls.op_class;
      alu_ctl        <= cls.alu_op;
      pc_jump        <= cls.pc_jump;
      mem_read       <= cls.mem_read;
      mem_write      <= cls.mem_write;
      predicated     <= acc.predicated;
      pred_operand   <= acc.pred_operand;
      gpr_read_en    <= acc.gpr_read_en;
      pred_read_en   <= acc.pred_read_en;
      gpr_write_en   <= acc.gpr_write_en;
      pred_write_en  <= acc.pred_write_en;
      gpr_rd_en      <= acc.gpr_rd_en;
      gpr_rd_addr_0  <= acc.gpr_rd_addr[0];
      gpr_rd_addr_1  <= acc.gpr_rd_addr[1];
      gpr_rd_addr_2  <= acc.gpr_rd_addr[2];
      pred_rd_en     <= acc.pred_rd_en;
      pred_rd_addr_0 <= acc.pred_rd_addr[0];
      pred_rd_addr_1 <= acc.pred_rd_addr[1];
      pred_rd_addr_2 <= acc.pred_rd_addr[2];
    end
  end

endmodule

`default_nettype wire

// File: hdl/harp_decoder.sv
// HARP instruction decode stage
// classifies the opcode, derives register-file accesses and registers
// the decoded control word, one cycle from instruction to outputs

`timescale 1ns/1ps
`default_nettype none

module harp_decoder (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            instr_valid,
  input  wire logic [harp_pkg::INSTR_W-1:0]    instruction,
  output logic                                 dec_valid,
  output harp_pkg::op_class_e                  op_class,
  output harp_pkg::alu_op_e                    alu_ctl,
  output logic                                 pc_jump,
  output logic                                 mem_read,
  output logic                                 mem_write,
  output logic                                 predicated,
  output harp_pkg::reg_addr_t                  pred_operand,
  output logic                                 gpr_read_en,
  output logic                                 pred_read_en,
  output logic                                 gpr_write_en,
  output logic                                 pred_write_en,
  output logic [harp_pkg::NUM_RD_PORTS-1:0]    gpr_rd_en,
  output harp_pkg::reg_addr_t                  gpr_rd_addr_0,
  output harp_pkg::reg_addr_t                  gpr_rd_addr_1,
  output harp_pkg::reg_addr_t                  gpr_rd_addr_2,
  output logic [harp_pkg::NUM_RD_PORTS-1:0]    pred_rd_en,
  output harp_pkg::reg_addr_t                  pred_rd_addr_0,
  output harp_pkg::reg_addr_t                  pred_rd_addr_1,
  output harp_pkg::reg_addr_t                  pred_rd_addr_2
);

  class_if      cls_bus ();
  reg_access_if acc_bus ();

  // combinational decode
  opcode_classifier u_classifier (
    .instruction (instruction),
    .cls         (cls_bus.src)
  );

  reg_access_decoder u_reg_access (
    .instruction (instruction),
    .cls         (cls_bus.dst),
    .acc         (acc_bus.src)
  );

  // registered output word
  decode_out_reg u_out_reg (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .cls            (cls_bus.dst),
    .acc            (acc_bus.dst),
    .dec_valid      (dec_valid),
    .op_class       (op_class),
    .alu_ctl        (alu_ctl),
    .pc_jump        (pc_jump),
    .mem_read       (mem_read),
    .mem_write      (mem_write),
    .predicated     (predicated),
    .pred_operand   (pred_operand),
    .gpr_read_en    (gpr_read_en),
    .pred_read_en   (pred_read_en),
    .gpr_write_en   (gpr_write_en),
    .pred_write_en  (pred_write_en),
    .gpr_rd_en      (gpr_rd_en),
    .gpr_rd_addr_0  (gpr_rd_addr_0),
    .gpr_rd_addr_1  (gpr_rd_addr_1),
    .gpr_rd_addr_2  (gpr_rd_addr_2),
    .pred_rd_en     (pred_rd_en),
    .pred_rd_addr_0 (pred_rd_addr_0),
    .pred_rd_addr_1 (pred_rd_addr_1),
    .pred_rd_addr_2 (pred_rd_addr_2)
  );

endmodule

`default_nettype wire

// File: hdl/harp_pkg.sv
// HARP decoder shared definitions
// instruction field layout, widths and the opcode, class and ALU enums
// for the 64-bit SIMT instruction format

`default_nettype none

package harp_pkg;

  // ====================================================================
  // instruction format
  // ====================================================================
  localparam int INSTR_W      = 64;
  localparam int REG_ADDR_W   = 5;
  localparam int OPCODE_W     = 6;
  localparam int ALU_OP_W     = 5;
  localparam int CLASS_W      = 4;
  localparam int NUM_RD_PORTS = 3;

  // field positions, msb first
  localparam int PRED_BIT_POS = 63;
  localparam int PRED_REG_LSB = 58;
  localparam int OPCODE_LSB   = 52;
  localparam int RS0_LSB      = 47;
  localparam int RS1_LSB      = 42;
  localparam int RS2_LSB      = 37;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ====================================================================
  // opcodes with real controls, at their ISA codes
  // ====================================================================
  typedef enum logic [OPCODE_W-1:0] {
    OP_NOP    = 6'h00,
    OP_NEG    = 6'h05,
    OP_NOT    = 6'h06,
    OP_AND    = 6'h07,
    OP_OR     = 6'h08,
    OP_XOR    = 6'h09,
    OP_ADD    = 6'h0a,
    OP_SUB    = 6'h0b,
    OP_MUL    = 6'h0c,
    OP_DIV    = 6'h0d,
    OP_MOD    = 6'h0e,
    OP_SHL    = 6'h0f,
    OP_SHR    = 6'h10,
    OP_ANDI   = 6'h11,
    OP_ORI    = 6'h12,
    OP_XORI   = 6'h13,
    OP_ADDI   = 6'h14,
    OP_SUBI   = 6'h15,
    OP_MULI   = 6'h16,
    OP_DIVI   = 6'h17,
    OP_MODI   = 6'h18,
    OP_SHLI   = 6'h19,
    OP_SHRI   = 6'h1a,
    OP_JALI   = 6'h1b,
    OP_JALR   = 6'h1c,
    OP_JMPI   = 6'h1d,
    OP_JMPR   = 6'h1e,
    OP_JALIS  = 6'h20,
    OP_JALRS  = 6'h21,
    OP_JMPRT  = 6'h22,
    OP_LD     = 6'h23,
    OP_ST     = 6'h24,
    OP_ANDP   = 6'h27,
    OP_ORP    = 6'h28,
    OP_XORP   = 6'h29,
    OP_NOTP   = 6'h2a,
    OP_ISNEG  = 6'h2b,
    OP_ISZERO = 6'h2c,
    OP_JMPRU  = 6'h2f
  } opcode_e;

  // operand class, drives which register ports are read
  typedef enum logic [CLASS_W-1:0] {
    CL_NONE     = 4'd0,
    CL_2REG     = 4'd1,
    CL_3REG     = 4'd2,
    CL_3IMM     = 4'd3,
    CL_LOAD     = 4'd4,
    CL_STORE    = 4'd5,
    CL_JUMP     = 4'd6,
    CL_3PREG    = 4'd7,
    CL_2PREG    = 4'd8,
    CL_PREG_REG = 4'd9
  } op_class_e;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_NOP    = 5'd0,
    ALU_NEG    = 5'd1,
    ALU_NOT    = 5'd2,
    ALU_AND    = 5'd3,
    ALU_OR     = 5'd4,
    ALU_XOR    = 5'd5,
    ALU_ADD    = 5'd6,
    ALU_SUB    = 5'd7,
    ALU_MUL    = 5'd8,
    ALU_DIV    = 5'd9,
    ALU_MOD    = 5'd10,
    ALU_SHL    = 5'd11,
    ALU_SHR    = 5'd12,
    ALU_ISNEG  = 5'd13,
    ALU_ISZERO = 5'd14
  } alu_op_e;

endpackage

`default_nettype wire

// File: hdl/opcode_classifier.sv
// opcode classifier
// maps the opcode field to an operand class, an ALU operation
// and the jump / memory flags, purely combinational

`timescale 1ns/1ps
`default_nettype none

module opcode_classifier (
  input  wire logic [harp_pkg::INSTR_W-1:0] instruction,
  class_if.src                              cls
);
  import harp_pkg::*;

  logic [OPCODE_W-1:0] opcode;

  assign opcode = instruction[OPCODE_LSB +: OPCODE_W];

  // ====================================================================
  // operand class
  // ====================================================================
  always_comb begin
    case (opcode)
      OP_NEG, OP_NOT:
        cls.op_class = CL_2REG;
      OP_AND, OP_OR, OP_XOR, OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD,
      OP_SHL, OP_SHR:
        cls.op_class = CL_3REG;
      OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI,
      OP_MODI, OP_SHLI, OP_SHRI:
        cls.op_class = CL_3IMM;
      OP_LD:
        cls.op_class = CL_LOAD;
      OP_ST:
        cls.op_class = CL_STORE;
      OP_JALI, OP_JALR, OP_JMPI, OP_JMPR, OP_JALIS, OP_JALRS, OP_JMPRT,
      OP_JMPRU:
        cls.op_class = CL_JUMP;
      OP_ANDP, OP_ORP, OP_XORP:
        cls.op_class = CL_3PREG;
      OP_NOTP:
        cls.op_class = CL_2PREG;
      OP_ISNEG, OP_ISZERO:
        cls.op_class = CL_PREG_REG;
      // nop and every unsupported opcode
      default:
        cls.op_class = CL_NONE;
    endcase
  end

  // ====================================================================
  // ALU operation
  // ====================================================================
  // register, immediate and predicate forms share one operation
  always_comb begin
    case (opcode)
      OP_NEG:                      cls.alu_op = ALU_NEG;
      OP_NOT, OP_NOTP:             cls.alu_op = ALU_NOT;
      OP_AND, OP_ANDI, OP_ANDP:    cls.alu_op = ALU_AND;
      OP_OR, OP_ORI, OP_ORP:       cls.alu_op = ALU_OR;
      OP_XOR, OP_XORI, OP_XORP:    cls.alu_op = ALU_XOR;
      // st computes base plus offset
      OP_ADD, OP_ADDI, OP_ST:      cls.alu_op = ALU_ADD;
      OP_SUB, OP_SUBI:             cls.alu_op = ALU_SUB;
      OP_MUL, OP_MULI:             cls.alu_op = ALU_MUL;
      OP_DIV, OP_DIVI:             cls.alu_op = ALU_DIV;
      OP_MOD, OP_MODI:             cls.alu_op = ALU_MOD;
      OP_SHL, OP_SHLI:             cls.alu_op = ALU_SHL;
      OP_SHR, OP_SHRI:             cls.alu_op = ALU_SHR;
      OP_ISNEG:                    cls.alu_op = ALU_ISNEG;
      OP_ISZERO:                   cls.alu_op = ALU_ISZERO;
      default:                     cls.alu_op = ALU_NOP;
    endcase
  end

  // function-unit flags follow the class
  assign cls.pc_jump   = (cls.op_class == CL_JUMP);
  assign cls.mem_read  = (cls.op_class == CL_LOAD);
  assign cls.mem_write = (cls.op_class == CL_STORE);

endmodule

`default_nettype wire

// File: hdl/reg_access_decoder.sv
// register access decoder
// turns the operand class and the rs fields into per-port read enables,
// read addresses and the aggregate register-file enables

`timescale 1ns/1ps
`default_nettype none

module reg_access_decoder (
  input  wire logic [harp_pkg::INSTR_W-1:0] instruction,
  class_if.dst                              cls,
  reg_access_if.src                         acc
);
  import harp_pkg::*;

  logic [NUM_RD_PORTS-1:0]      gpr_en;
  logic [NUM_RD_PORTS-1:0]      pred_en;
  reg_addr_t [NUM_RD_PORTS-1:0] rs;

  // operand fields, port n reads field rs n
  assign rs[0] = instruction[RS0_LSB +: REG_ADDR_W];
  assign rs[1] = instruction[RS1_LSB +: REG_ADDR_W];
  assign rs[2] = instruction[RS2_LSB +: REG_ADDR_W];

  // ====================================================================
  // port enables per class
  // ====================================================================
  always_comb begin
    gpr_en  = '0;
    pred_en = '0;
    case (cls.op_class)
      CL_2REG:
        gpr_en = 3'b010;
      CL_3REG:
        gpr_en = 3'b111;
      CL_3IMM, CL_LOAD, CL_STORE:
        gpr_en = 3'b011;
      CL_3PREG:
        pred_en = 3'b111;
      CL_2PREG:
        pred_en = 3'b011;
      // compare reads a GPR and names the predicate destination
      CL_PREG_REG: begin
        gpr_en  = 3'b010;
        pred_en = 3'b001;
      end
      default: begin
        gpr_en  = '0;
        pred_en = '0;
      end
    endcase
  end

  // disabled ports read address 0
  always_comb begin
    for (int n = 0; n < NUM_RD_PORTS; n++) begin
      acc.gpr_rd_addr[n]  = gpr_en[n] ? rs[n] : '0;
      acc.pred_rd_addr[n] = pred_en[n] ? rs[n] : '0;
    end
  end

  assign acc.gpr_rd_en  = gpr_en;
  assign acc.pred_rd_en = pred_en;

  // ====================================================================
  // aggregate enables and guard
  // ====================================================================
  assign acc.gpr_read_en   = |gpr_en;
  // a guarded instruction always reads its predicate
  assign acc.pred_read_en  = (|pred_en) | instruction[PRED_BIT_POS];
  assign acc.gpr_write_en  = cls.op_class inside {CL_2REG, CL_3REG, CL_3IMM, CL_LOAD};
  assign acc.pred_write_en = cls.op_class inside {CL_3PREG, CL_2PREG, CL_PREG_REG};

  assign acc.predicated    = instruction[PRED_BIT_POS];
  assign acc.pred_operand  = instruction[PRED_REG_LSB +: REG_ADDR_W];

endmodule

`default_nettype wire

// File: hdl/reg_access_if.sv
// register access bundle
// per-port read enables and addresses for the GPR and predicate files,
// aggregate enables and the predicate guard

`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;
  import harp_pkg::*;

  // per-port reads
  logic [NUM_RD_PORTS-1:0]      gpr_rd_en;
  reg_addr_t [NUM_RD_PORTS-1:0] gpr_rd_addr;
  logic [NUM_RD_PORTS-1:0]      pred_rd_en;
  reg_addr_t [NUM_RD_PORTS-1:0] pred_rd_addr;

  // aggregates
  logic gpr_read_en;
  logic pred_read_en;
  logic gpr_write_en;
  logic pred_write_en;

  // guard
  logic      predicated;
  reg_addr_t pred_operand;

  modport src (
    output gpr_rd_en, gpr_rd_addr, pred_rd_en, pred_rd_addr,
    output gpr_read_en, pred_read_en, gpr_write_en, pred_write_en,
    output predicated, pred_operand
  );

  modport dst (
    input gpr_rd_en, gpr_rd_addr, pred_rd_en, pred_rd_addr,
    input gpr_read_en, pred_read_en, gpr_write_en, pred_write_en,
    input predicated, pred_operand
  );

endinterface

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the HARP decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_harp_decoder -f compile.f

./obj_dir/Vtb_harp_decoder > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// File: tests/decode_checker.sv
// decode checker
// reference model of the decode rules; predicts each output word one
// cycle ahead of the DUT and compares every output against it

`timescale 1ns/1ps
`default_nettype none

module decode_checker (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         instr_valid,
  input  wire logic [harp_pkg::INSTR_W-1:0] instruction,
  input  wire logic                         dec_valid,
  input  wire harp_pkg::op_class_e          op_class,
  input  wire harp_pkg::alu_op_e            alu_ctl,
  input  wire logic                         pc_jump, mem_read, mem_write, predicated,
  input  wire harp_pkg::reg_addr_t          pred_operand,
  input  wire logic                         gpr_read_en, pred_read_en,
  input  wire logic                         gpr_write_en, pred_write_en,
  input  wire logic [2:0]                   gpr_rd_en, pred_rd_en,
  input  wire harp_pkg::reg_addr_t          gpr_rd_addr_0, gpr_rd_addr_1, gpr_rd_addr_2,
  input  wire harp_pkg::reg_addr_t          pred_rd_addr_0, pred_rd_addr_1, pred_rd_addr_2,
  output int                                error_count,
  output int                                check_count
);
  import harp_pkg::*;

  typedef struct packed {
    logic             valid;
    op_class_e        op_class;
    alu_op_e          alu;
    logic             pc_jump;
    logic             mem_read;
    logic             mem_write;
    logic             predicated;
    reg_addr_t        pred_operand;
    logic             gpr_read_en;
    logic             pred_read_en;
    logic             gpr_write_en;
    logic             pred_write_en;
    logic [2:0]       gpr_rd_en;
    reg_addr_t [2:0]  gpr_rd_addr;
    logic [2:0]       pred_rd_en;
    reg_addr_t [2:0]  pred_rd_addr;
  } word_t;

  word_t exp_w;
  bit    have_exp;

  // ======================================================================
  // reference decode
  // ======================================================================
  function automatic word_t ref_decode(input logic [INSTR_W-1:0] ins);
    word_t               w;
    logic [OPCODE_W-1:0] op;
    reg_addr_t [2:0]     rs;
    logic [2:0]          g;
    logic [2:0]          p;
    w = '0;
    g = '0;
    p = '0;
    op = ins[OPCODE_LSB +: OPCODE_W];
    rs[0] = ins[RS0_LSB +: REG_ADDR_W];
    rs[1] = ins[RS1_LSB +: REG_ADDR_W];
    rs[2] = ins[RS2_LSB +: REG_ADDR_W];
    w.valid = 1'b1;
    w.predicated = ins[PRED_BIT_POS];
    w.pred_operand = ins[PRED_REG_LSB +: REG_ADDR_W];
    if (op == OP_NEG || op == OP_NOT) begin
      w.op_class = CL_2REG;
      w.alu = (op == OP_NEG) ? ALU_NEG : ALU_NOT;
      g = 3'b010;
      w.gpr_write_en = 1'b1;
    end else if (op >= OP_AND && op <= OP_SHR) begin
      // register and immediate ops run in ALU order starting at and
      w.op_class = CL_3REG;
      w.alu = alu_op_e'(5'(ALU_AND) + 5'(op - OP_AND));
      g = 3'b111;
      w.gpr_write_en = 1'b1;
    end else if (op >= OP_ANDI && op <= OP_SHRI) begin
      w.op_class = CL_3IMM;
      w.alu = alu_op_e'(5'(ALU_AND) + 5'(op - OP_ANDI));
      g = 3'b011;
      w.gpr_write_en = 1'b1;
    end else if (op == OP_LD) begin
      w.op_class = CL_LOAD;
      w.mem_read = 1'b1;
      g = 3'b011;
      w.gpr_write_en = 1'b1;
    end else if (op == OP_ST) begin
      w.op_class = CL_STORE;
      w.mem_write = 1'b1;
      w.alu = ALU_ADD;
      g = 3'b011;
    end else if ((op >= OP_JALI && op <= OP_JMPR) || (op >= OP_JALIS && op <= OP_JMPRT) ||
                 op == OP_JMPRU) begin
      w.op_class = CL_JUMP;
      w.pc_jump = 1'b1;
    end else if (op >= OP_ANDP && op <= OP_XORP) begin
      w.op_class = CL_3PREG;
      w.alu = alu_op_e'(5'(ALU_AND) + 5'(op - OP_ANDP));
      p = 3'b111;
      w.pred_write_en = 1'b1;
    end else if (op == OP_NOTP) begin
      w.op_class = CL_2PREG;
      w.alu = ALU_NOT;
      p = 3'b011;
      w.pred_write_en = 1'b1;
    end else if (op == OP_ISNEG || op == OP_ISZERO) begin
      w.op_class = CL_PREG_REG;
      w.alu = (op == OP_ISNEG) ? ALU_ISNEG : ALU_ISZERO;
      g = 3'b010;
      p = 3'b001;
      w.pred_write_en = 1'b1;
    end
    w.gpr_rd_en = g;
    w.pred_rd_en = p;
    for (int n = 0; n < 3; n++) begin
      w.gpr_rd_addr[n] = g[n] ? rs[n] : '0;
      w.pred_rd_addr[n] = p[n] ? rs[n] : '0;
    end
    w.gpr_read_en = |g;
    w.pred_read_en = (|p) | w.predicated;
    return w;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERROR %s expected 0x%0h got 0x%0h at %0t", name, exp_v, act_v, $time);
      error_count++;
    end
  endtask

  // ======================================================================
  // expectation and comparison
  // ======================================================================
  // reset and an idle input both predict an all-zero bubble
  always @(posedge clk) begin
    have_exp <= 1'b1;
    if (!rst && instr_valid) begin
      exp_w <= ref_decode(instruction);
    end else begin
      exp_w <= '0;
    end
  end

  // outputs only move on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (have_exp) begin
      check_count++;
      if (exp_w.valid && dec_valid !== 1'b1) begin
        $display("dec_valid missing one cycle after an accepted instruction at %0t", $time);
        error_count++;
      end else if (!exp_w.valid && dec_valid !== 1'b0) begin
        $display("dec_valid not low at %0t although no instruction was accepted", $time);
        error_count++;
      end
      compare_value("op_class", 32'(exp_w.op_class), 32'(op_class));
      compare_value("alu_ctl", 32'(exp_w.alu), 32'(alu_ctl));
      compare_value("pc_jump", 32'(exp_w.pc_jump), 32'(pc_jump));
      compare_value("mem_read", 32'(exp_w.mem_read), 32'(mem_read));
      compare_value("mem_write", 32'(exp_w.mem_write), 32'(mem_write));
      compare_value("predicated", 32'(exp_w.predicated), 32'(predicated));
      compare_value("pred_operand", 32'(exp_w.pred_operand), 32'(pred_operand));
      compare_value("gpr_read_en", 32'(exp_w.gpr_read_en), 32'(gpr_read_en));
      compare_value("pred_read_en", 32'(exp_w.pred_read_en), 32'(pred_read_en));
      compare_value("gpr_write_en", 32'(exp_w.gpr_write_en), 32'(gpr_write_en));
      compare_value("pred_write_en", 32'(exp_w.pred_write_en), 32'(pred_write_en));
      compare_value("gpr_rd_en", 32'(exp_w.gpr_rd_en), 32'(gpr_rd_en));
      compare_value("gpr_rd_addr_0", 32'(exp_w.gpr_rd_addr[0]), 32'(gpr_rd_addr_0));
      compare_value("gpr_rd_addr_1", 32'(exp_w.gpr_rd_addr[1]), 32'(gpr_rd_addr_1));
      compare_value("gpr_rd_addr_2", 32'(exp_w.gpr_rd_addr[2]), 32'(gpr_rd_addr_2));
      compare_value("pred_rd_en", 32'(exp_w.pred_rd_en), 32'(pred_rd_en));
      compare_value("pred_rd_addr_0", 32'(exp_w.pred_rd_addr[0]), 32'(pred_rd_addr_0));
      compare_value("pred_rd_addr_1", 32'(exp_w.pred_rd_addr[1]), 32'(pred_rd_addr_1));
      compare_value("pred_rd_addr_2", 32'(exp_w.pred_rd_addr[2]), 32'(pred_rd_addr_2));
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_harp_decoder.sv
// testbench for the HARP decode stage
// clock, reset, directed opcode sweeps, random valid / idle traffic,
// watchdog and the final verdict

`timescale 1ns/1ps
`default_nettype none

module tb_harp_decoder;
  import harp_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int RANDOM_COUNT = 400;
  // two sweeps over all 64 opcodes plus idle gaps
  localparam int SWEEP_CYCLES  = 2 * 64 + 8;
  // random phase is about 80 % valid
  localparam int RANDOM_CYCLES = RANDOM_COUNT * 5 / 4;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + SWEEP_CYCLES + RANDOM_CYCLES + 8;
  localparam int TIMEOUT_NS    = 2 * TOTAL_CYCLES * CLK_PERIOD;
  localparam int unsigned RAND_SEED = 32'h30c1_2a6d;

  logic                    clk;
  logic                    rst;
  logic                    instr_valid;
  logic [INSTR_W-1:0]      instruction;
  logic                    dec_valid;
  op_class_e               op_class;
  alu_op_e                 alu_ctl;
  logic                    pc_jump, mem_read, mem_write, predicated;
  reg_addr_t               pred_operand;
  logic                    gpr_read_en, pred_read_en, gpr_write_en, pred_write_en;
  logic [NUM_RD_PORTS-1:0] gpr_rd_en, pred_rd_en;
  reg_addr_t               gpr_rd_addr_0, gpr_rd_addr_1, gpr_rd_addr_2;
  reg_addr_t               pred_rd_addr_0, pred_rd_addr_1, pred_rd_addr_2;
  int                      error_count;
  int                      check_count;

  harp_decoder u_dut (.*);

  decode_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns with the test still running", TIMEOUT_NS);
    $display("=== FAIL ===");
    $finish;
  end

  // opcode and predicate bit fixed, every other field random
  task automatic drive_instr(input logic [OPCODE_W-1:0] op, input logic pred);
    logic [63:0] r;
    @(negedge clk);
    r = {$urandom, $urandom};
    instr_valid = 1'b1;
    instruction = {pred, r[62:58], op, r[51:0]};
  endtask

  // idle input still carries garbage, which must not leak out
  task automatic idle_cycle();
    @(negedge clk);
    instr_valid = 1'b0;
    instruction = {$urandom, $urandom};
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================
  initial begin
    int unsigned seed_discard;
    int          issued;
    logic        v;
    rst = 1'b1;
    instr_valid = 1'b0;
    instruction = '0;
    seed_discard = $urandom(RAND_SEED);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_cycle();
    idle_cycle();

    // first sweep unguarded, second with the predicated bit set
    for (int pass = 0; pass < 2; pass++) begin
      for (int op = 0; op < 64; op++) begin
        drive_instr(6'(op), pass[0]);
      end
      idle_cycle();
    end

    issued = 0;
    while (issued < RANDOM_COUNT) begin
      @(negedge clk);
      v = ($urandom % 100) < 80;
      instr_valid = v;
      instruction = {$urandom, $urandom};
      if (v) begin
        issued++;
      end
    end

    // drain the last word before the verdict
    idle_cycle();
    while (dec_valid) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    $display("%0d words checked, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
